// ==== sources.f ====
+incdir+source
source/cpu_pkg.sv
source/fetch_ctrl.sv
source/pc_counter.sv
source/decode_stage.sv
source/id_ex_pipe_reg.sv
source/execute_stage.sv
source/cpu_core.sv
test/cpu_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it and judge the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  -f sources.f \
  --top-module cpu_core_tb \
  -o cpu_core_sim

./obj_dir/cpu_core_sim > sim.log 2>&1
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed"
  exit 1
fi

// ==== test/cpu_core_tb.sv ====
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_core_tb;

  localparam int n_wb    = 19;  // Register writes the program makes
  localparam int n_fetch = 26;  // Fetches along the taken path
  localparam int wb_wait = 100; // Cycles allowed for one writeback or the halt
  localparam int quiet   = 200; // Cycles watched after the halt

  logic                 clk;
  logic                 rst;
  logic                 fetch_req;
  logic [`CPU_PC_W-1:0] fetch_pc;
  logic                 fetch_ack;
  cpu_pkg::instr_u      fetch_instr;
  cpu_pkg::wb_port_t    wb;
  logic                 halted;

  int wb_errs    = 0;
  int pc_errs    = 0;
  int other_errs = 0;
  int pc_idx     = 0; // Next entry of the fetch trace
  int delay_left = 0; // Idle cycles before the next ack
  bit timed_out  = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // Program and expected results
  //////////////////////////////////////////////////////////////////////

  // 5FEE is the wrong-path marker, LLI r15 that must never run
  localparam logic [15:0] prog [32] = '{
    16'h5105, 16'h52FD, 16'h0312, 16'h1421, 16'h2512, 16'h3611, 16'h577F, 16'h0777,
    16'h0777, 16'h0777, 16'h0777, 16'h0777, 16'h0777, 16'h0777, 16'h0777, 16'h0777,
    16'h2916, 16'h6101, 16'h5FEE, 16'h6301, 16'h5FEE, 16'h6201, 16'h5A01, 16'h4A02,
    16'h6201, 16'h5FEE, 16'h6301, 16'h6001, 16'h5FEE, 16'hF000, 16'h5FEE, 16'h5FEE
  };

  // Doubling r7 nine times wraps 7F00 into FE00, the AND leaves N set
  localparam cpu_pkg::wb_port_t exp_wb [n_wb] = '{
    {1'b1, 4'd1, 16'h0005},  {1'b1, 4'd2, 16'hFFFD},  {1'b1, 4'd3, 16'h0002},
    {1'b1, 4'd4, 16'hFFF8},  {1'b1, 4'd5, 16'h0005},  {1'b1, 4'd6, 16'h0000},
    {1'b1, 4'd7, 16'h007F},  {1'b1, 4'd7, 16'h00FE},  {1'b1, 4'd7, 16'h01FC},
    {1'b1, 4'd7, 16'h03F8},  {1'b1, 4'd7, 16'h07F0},  {1'b1, 4'd7, 16'h0FE0},
    {1'b1, 4'd7, 16'h1FC0},  {1'b1, 4'd7, 16'h3F80},  {1'b1, 4'd7, 16'h7F00},
    {1'b1, 4'd7, 16'hFE00},  {1'b1, 4'd9, 16'h0000},  {1'b1, 4'd10, 16'h0001},
    {1'b1, 4'd10, 16'h0003}
  };

  // Taken branches at 17, 19, 24 and 27 skip 18, 20, 25 and 28
  localparam logic [`CPU_PC_W-1:0] fetch_trace [n_fetch] = '{
    16'd0,  16'd1,  16'd2,  16'd3,  16'd4,  16'd5,  16'd6,  16'd7,
    16'd8,  16'd9,  16'd10, 16'd11, 16'd12, 16'd13, 16'd14, 16'd15,
    16'd16, 16'd17, 16'd19, 16'd21, 16'd22, 16'd23, 16'd24, 16'd26,
    16'd27, 16'd29
  };

  cpu_core u_dut (
    .clk(clk), .rst(rst), .fetch_req(fetch_req), .fetch_pc(fetch_pc),
    .fetch_ack(fetch_ack), .fetch_instr(fetch_instr), .wb(wb), .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_wb(input cpu_pkg::wb_port_t got, input cpu_pkg::wb_port_t exp);
    if (got.rd !== exp.rd) begin
      $display("Error t=%0t wb.rd expected %0d got %0d", $time, exp.rd, got.rd);
      wb_errs++;
    end
    if (got.data !== exp.data) begin
      $display("Error t=%0t wb.data expected %h got %h", $time, exp.data, got.data);
      wb_errs++;
    end
  endtask

  task automatic check_pc(input logic [`CPU_PC_W-1:0] got, input logic [`CPU_PC_W-1:0] exp);
    if (got !== exp) begin
      $display("Error t=%0t fetch_pc expected %0d got %0d", $time, exp, got);
      pc_errs++;
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("Error t=%0t %s expected %b got %b", $time, name, exp, got);
      other_errs++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Instruction supplier
  //////////////////////////////////////////////////////////////////////

  initial begin : instr_supplier
    fetch_ack   = 1'b0;
    fetch_instr = '0;
    void'($urandom(32'h8d534c05));
    forever begin
      @(posedge clk);
      #1;
      if (fetch_ack) begin
        if (!fetch_req)
          fetch_ack = 1'b0;                   // Phase 4 once req has fallen
      end else if (fetch_req) begin
        if (delay_left == 0) begin
          if (pc_idx < n_fetch) begin
            check_pc(fetch_pc, fetch_trace[pc_idx]);
          end else begin
            $display("Unexpected fetch at PC %0d, t=%0t", fetch_pc, $time);
            pc_errs++;
          end
          pc_idx++;
          fetch_instr = prog[fetch_pc[4:0]];
          fetch_ack   = 1'b1;                 // Phase 2 with the word valid
        end else begin
          delay_left--;
        end
      end else begin
        delay_left = $urandom % 4; // Slow ack of 0 to 3 cycles for the next req
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main_flow
    int cycles;
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    // Idle state straight after reset
    check_bit(fetch_req, 1'b0, "fetch_req");
    check_bit(wb.valid, 1'b0, "wb.valid");
    check_bit(halted, 1'b0, "halted");
    check_pc(fetch_pc, '0);
    for (int i = 0; i < n_wb && !timed_out; i++) begin
      cycles = 0;
      do begin
        @(negedge clk); // Valid is registered, so it is steady here
        cycles++;
      end while (!wb.valid && cycles < wb_wait);
      if (!wb.valid) begin
        $display("Writeback %0d did not arrive within %0d cycles", i, wb_wait);
        other_errs++;
        timed_out = 1'b1;
      end else begin
        check_wb(wb, exp_wb[i]);
      end
    end
    if (!timed_out) begin
      cycles = 0;
      do begin
        @(negedge clk);
        cycles++;
        if (wb.valid) begin
          $display("Extra writeback to r%0d before the halt, t=%0t", wb.rd, $time);
          other_errs++;
        end
      end while (!halted && cycles < wb_wait);
      if (!halted) begin
        $display("The core did not halt within %0d cycles", wb_wait);
        other_errs++;
      end else begin
        // Halted core stays silent on both ports
        for (int c = 0; c < quiet; c++) begin
          @(negedge clk);
          check_bit(fetch_req, 1'b0, "fetch_req");
          check_bit(wb.valid, 1'b0, "wb.valid");
          check_bit(halted, 1'b1, "halted");
        end
      end
      if (pc_idx != n_fetch) begin
        $display("Only %0d of %0d expected fetches took place", pc_idx, n_fetch);
        other_errs++;
      end
    end
    $display("Errors: writeback %0d, fetch %0d, other %0d", wb_errs, pc_errs, other_errs);
    if (wb_errs + pc_errs + other_errs == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== source/cpu_core.sv ====
`timescale 1ns/1ps

`include "cpu_defs.svh"

module cpu_core (
  input  logic                 clk,
  input  logic                 rst,
  output logic                 fetch_req,   // Four-phase request
  output logic [`CPU_PC_W-1:0] fetch_pc,    // Stable while req is high
  input  logic                 fetch_ack,   // Four-phase acknowledge
  input  cpu_pkg::instr_u      fetch_instr, // Valid while ack is high
  output cpu_pkg::wb_port_t    wb,          // Observed register writes
  output logic                 halted       // HLT has executed
);

  logic                 issue;
  logic                 advance;
  logic                 redirect;
  logic                 halt;
  logic [`CPU_PC_W-1:0] target;
  cpu_pkg::instr_u      instr;
  cpu_pkg::ex_ctrl_t    id_ex_ctrl;   // Decode side of the pipeline register
  cpu_pkg::wb_ctrl_t    id_wb_ctrl;
  logic [`CPU_PC_W-1:0] id_pc_next;
  cpu_pkg::ex_ctrl_t    ex_ctrl;      // Execute side of the pipeline register
  cpu_pkg::wb_ctrl_t    ex_wb_ctrl;
  logic [`CPU_PC_W-1:0] ex_pc_next;

  fetch_ctrl u_fetch_ctrl (
    .clk(clk), .rst(rst), .fetch_req(fetch_req), .fetch_ack(fetch_ack),
    .fetch_instr(fetch_instr), .redirect(redirect), .halt(halt),
    .issue(issue), .instr(instr), .advance(advance)
  );

  pc_counter u_pc_counter (
    .clk(clk), .rst(rst), .advance(advance), .redirect(redirect),
    .target(target), .pc(fetch_pc)
  );

  decode_stage u_decode_stage (
    .clk(clk), .rst(rst), .issue(issue), .instr(instr), .pc(fetch_pc), .wb(wb),
    .ex_ctrl(id_ex_ctrl), .wb_ctrl(id_wb_ctrl), .pc_next(id_pc_next)
  );

  // Any cycle without a new word enters execute as a bubble
  id_ex_pipe_reg u_id_ex_pipe_reg (
    .clk(clk), .rst(rst), .flush(!issue), .pc_next_in(id_pc_next),
    .ex_in(id_ex_ctrl), .wb_in(id_wb_ctrl),
    .pc_next_out(ex_pc_next), .ex_out(ex_ctrl), .wb_out(ex_wb_ctrl)
  );

  execute_stage u_execute_stage (
    .clk(clk), .rst(rst), .pc_next(ex_pc_next), .ex_ctrl(ex_ctrl),
    .wb_ctrl(ex_wb_ctrl), .wb(wb), .redirect(redirect), .target(target),
    .halt(halt)
  );

  assign halted = halt;

endmodule

// ==== source/execute_stage.sv ====
`timescale 1ns/1ps

`include "cpu_defs.svh"

module execute_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`CPU_PC_W-1:0] pc_next,  // Address after this instruction
  input  cpu_pkg::ex_ctrl_t    ex_ctrl,  // Operands and ALU controls
  input  cpu_pkg::wb_ctrl_t    wb_ctrl,  // Destination controls
  output cpu_pkg::wb_port_t    wb,       // Registered register write
  output logic                 redirect, // Taken branch this cycle
  output logic [`CPU_PC_W-1:0] target,   // Branch destination
  output logic                 halt      // HLT seen, stays high
);

  logic [`CPU_DATA_W-1:0]    a;
  logic [`CPU_DATA_W-1:0]    b;
  logic [`CPU_DATA_W-1:0]    result;
  logic                      ovf;       // Signed overflow of add or subtract
  logic                      taken;     // Condition holds on stored flags
  cpu_pkg::flags_t           flags_q;
  logic                      halt_q;
  logic                      wb_valid_q;
  logic [`CPU_REG_IDX_W-1:0] wb_rd_q;
  logic [`CPU_DATA_W-1:0]    wb_data_q;

  assign a = ex_ctrl.op_a;
  assign b = ex_ctrl.op_b;

  //////////////////////////////////////////////////////////////////////
  // ALU
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    ovf = 1'b0;
    case (ex_ctrl.alu_op)
      cpu_pkg::ALU_ADD: begin
        result = a + b;
        // Same-signed inputs giving the other sign
        ovf = (a[`CPU_DATA_W-1] == b[`CPU_DATA_W-1]) &&
              (result[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
      end
      cpu_pkg::ALU_SUB: begin
        result = a - b;
        ovf = (a[`CPU_DATA_W-1] != b[`CPU_DATA_W-1]) &&
              (result[`CPU_DATA_W-1] != a[`CPU_DATA_W-1]);
      end
      cpu_pkg::ALU_AND: result = a & b;
      cpu_pkg::ALU_XOR: result = a ^ b;
      default:          result = b; // LLI loads the immediate as is
    endcase
  end

  // Flags hold between writers, each group only moves under its enable
  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else begin
      if (ex_ctrl.z_en) flags_q.z <= (result == '0);
      if (ex_ctrl.nv_en) begin
        flags_q.n <= result[`CPU_DATA_W-1];
        flags_q.v <= ovf;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Branch and halt
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (ex_ctrl.cond)
      2'd0:    taken = 1'b1;       // Unconditional
      2'd1:    taken = flags_q.z;
      2'd2:    taken = !flags_q.z;
      default: taken = flags_q.n;
    endcase
  end

  assign redirect = ex_ctrl.is_branch && taken; // PC loads target on this edge
  assign target   = pc_next + ex_ctrl.offset;

  always_ff @(posedge clk) begin
    if (rst)
      halt_q <= 1'b0;
    else if (wb_ctrl.hlt)
      halt_q <= 1'b1;
  end

  assign halt = halt_q || wb_ctrl.hlt; // Fetch stops before it starts another req

  // Writeback strobe and payload, one cycle after the ID/EX load
  always_ff @(posedge clk) begin
    if (rst)
      wb_valid_q <= 1'b0;
    else
      wb_valid_q <= wb_ctrl.reg_write;
  end

  always_ff @(posedge clk) begin
    wb_rd_q   <= wb_ctrl.rd;
    wb_data_q <= result;
  end

  always_comb begin
    wb.valid = wb_valid_q;
    wb.rd    = wb_rd_q;
    wb.data  = wb_data_q;
  end

endmodule

// ==== source/id_ex_pipe_reg.sv ====
`timescale 1ns/1ps

`include "cpu_defs.svh"

module id_ex_pipe_reg (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,       // Load a bubble instead of the inputs
  input  logic [`CPU_PC_W-1:0] pc_next_in,  // Next PC from decode
  input  cpu_pkg::ex_ctrl_t    ex_in,       // Execute group from decode
  input  cpu_pkg::wb_ctrl_t    wb_in,       // Writeback group from decode
  output logic [`CPU_PC_W-1:0] pc_next_out, // Next PC for branch targets
  output cpu_pkg::ex_ctrl_t    ex_out,      // Execute group to execute
  output cpu_pkg::wb_ctrl_t    wb_out       // Writeback group to execute
);

  logic                 clr; // Either reset or flush empties the controls
  logic [`CPU_PC_W-1:0] pc_next_q;
  cpu_pkg::ex_ctrl_t    ex_q;
  cpu_pkg::wb_ctrl_t    wb_q;

  assign clr = rst || flush;

  //////////////////////////////////////////////////////////////////////
  // PC group
  //////////////////////////////////////////////////////////////////////

  // A bubble has no branch, so the PC may keep whatever it holds
  always_ff @(posedge clk) begin
    if (rst)
      pc_next_q <= '0;
    else
      pc_next_q <= pc_next_in;
  end

  //////////////////////////////////////////////////////////////////////
  // Control groups
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (clr) begin
      ex_q <= '0; // All enables low, branch off
      wb_q <= '0; // No write, no halt
    end else begin
      ex_q <= ex_in;
      wb_q <= wb_in;
    end
  end

  assign pc_next_out = pc_next_q;
  assign ex_out      = ex_q;
  assign wb_out      = wb_q;

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ps

`include "cpu_defs.svh"

module decode_stage (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 issue,   // instr is a fresh word this cycle
  input  cpu_pkg::instr_u      instr,   // Fetched word
  input  logic [`CPU_PC_W-1:0] pc,      // Already points past instr
  input  cpu_pkg::wb_port_t    wb,      // Register write from execute
  output cpu_pkg::ex_ctrl_t    ex_ctrl, // Operands and ALU controls
  output cpu_pkg::wb_ctrl_t    wb_ctrl, // Destination controls
  output logic [`CPU_PC_W-1:0] pc_next  // Return address base for branches
);

  logic [`CPU_DATA_W-1:0] regs [`CPU_NREGS];
  logic [`CPU_DATA_W-1:0] rs_val;  // First source read
  logic [`CPU_DATA_W-1:0] rt_val;  // Second source read
  logic [`CPU_DATA_W-1:0] rd_val;  // Destination read, ADDI adds to it
  logic [`CPU_DATA_W-1:0] imm_ext; // Immediate as an operand
  logic [`CPU_PC_W-1:0]   off_ext; // Immediate as a branch offset

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `CPU_NREGS; i++)
        regs[i] <= '0;
    end else if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Asynchronous reads; the older instruction has written back by now
  assign rs_val = regs[instr.r.rs];
  assign rt_val = regs[instr.r.rt];
  assign rd_val = regs[instr.i.rd]; // Same field position as r.rd

  assign imm_ext = {{(`CPU_DATA_W - `CPU_IMM_W){instr.i.imm[`CPU_IMM_W-1]}}, instr.i.imm};
  assign off_ext = {{(`CPU_PC_W - `CPU_IMM_W){instr.i.imm[`CPU_IMM_W-1]}}, instr.i.imm};

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    // Defaults describe an R-format word with no side effects
    ex_ctrl           = '0;
    ex_ctrl.op_a      = rs_val;
    ex_ctrl.op_b      = rt_val;
    ex_ctrl.cond      = instr.i.rd[1:0]; // Condition code lives in rd
    ex_ctrl.offset    = off_ext;
    wb_ctrl           = '0;
    wb_ctrl.rd        = instr.r.rd;
    case (instr.r.opcode)
      cpu_pkg::ADD, cpu_pkg::SUB: begin
        ex_ctrl.alu_op    = (instr.r.opcode == cpu_pkg::ADD) ? cpu_pkg::ALU_ADD
                                                             : cpu_pkg::ALU_SUB;
        ex_ctrl.z_en      = 1'b1;
        ex_ctrl.nv_en     = 1'b1; // Arithmetic updates every flag
        wb_ctrl.reg_write = 1'b1;
      end
      cpu_pkg::AND, cpu_pkg::XOR: begin
        ex_ctrl.alu_op    = (instr.r.opcode == cpu_pkg::AND) ? cpu_pkg::ALU_AND
                                                             : cpu_pkg::ALU_XOR;
        ex_ctrl.z_en      = 1'b1; // Logic ops leave N and V alone
        wb_ctrl.reg_write = 1'b1;
      end
      cpu_pkg::ADDI: begin
        ex_ctrl.op_a      = rd_val;  // rd plus the immediate
        ex_ctrl.op_b      = imm_ext;
        ex_ctrl.alu_op    = cpu_pkg::ALU_ADD;
        ex_ctrl.z_en      = 1'b1;
        ex_ctrl.nv_en     = 1'b1;
        wb_ctrl.reg_write = 1'b1;
      end
      cpu_pkg::LLI: begin
        ex_ctrl.op_b      = imm_ext;
        ex_ctrl.alu_op    = cpu_pkg::ALU_PASS;
        wb_ctrl.reg_write = 1'b1;
      end
      cpu_pkg::B:   ex_ctrl.is_branch = 1'b1;
      cpu_pkg::HLT: wb_ctrl.hlt       = 1'b1;
      default: ; // Unused opcodes run as no-ops
    endcase
    // Nothing takes effect unless the word was really issued
    ex_ctrl.z_en      = ex_ctrl.z_en && issue;
    ex_ctrl.nv_en     = ex_ctrl.nv_en && issue;
    ex_ctrl.is_branch = ex_ctrl.is_branch && issue;
    wb_ctrl.reg_write = wb_ctrl.reg_write && issue;
    wb_ctrl.hlt       = wb_ctrl.hlt && issue;
  end

  assign pc_next = pc;

endmodule

// ==== source/pc_counter.sv ====
`timescale 1ns/1ps

`include "cpu_defs.svh"

module pc_counter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 advance,  // A fetch was accepted this edge
  input  logic                 redirect, // Taken branch, load target
  input  logic [`CPU_PC_W-1:0] target,   // Branch destination
  output logic [`CPU_PC_W-1:0] pc        // Address for the next fetch
);

  logic [`CPU_PC_W-1:0] pc_q;

  // Branch target beats the increment when both land on one edge
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= '0; // Execution starts at address zero
    end else if (redirect) begin
      pc_q <= target;
    end else if (advance) begin
      pc_q <= pc_q + `CPU_PC_W'(1); // One word per instruction
    end
  end

  // Also the next PC of the word just issued, since it stepped at capture
  assign pc = pc_q;

endmodule

// ==== source/fetch_ctrl.sv ====
`timescale 1ns/1ps

module fetch_ctrl (
  input  logic            clk,
  input  logic            rst,
  output logic            fetch_req,   // Request to the instruction supplier
  input  logic            fetch_ack,   // Supplier has the word ready
  input  cpu_pkg::instr_u fetch_instr, // Word from the supplier, valid with ack
  input  logic            redirect,    // Taken branch in execute
  input  logic            halt,        // HLT reached execute
  output logic            issue,       // One-cycle pulse, instr is new
  output cpu_pkg::instr_u instr,       // Last accepted word
  output logic            advance      // Step the PC on this edge
);

  // IDLE waits one cycle so a new req only rises after ack is low
  typedef enum logic [1:0] {IDLE, REQ, DROP, HALTED} state_e;

  state_e          state_q;
  logic            pending_q; // Word in flight was requested on the old path
  logic            issue_q;
  cpu_pkg::instr_u instr_q;
  logic            accept;    // Ack seen while requesting
  logic            discard;   // Word in flight must not run

  assign fetch_req = (state_q == REQ);
  assign accept    = (state_q == REQ) && fetch_ack;
  assign discard   = pending_q || redirect || halt; // Old path or past a halt
  assign advance   = accept && !discard;
  assign issue     = issue_q;
  assign instr     = instr_q;

  //////////////////////////////////////////////////////////////////////
  // Four-phase handshake
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q   <= IDLE;
      pending_q <= 1'b0;
      issue_q   <= 1'b0;
    end else begin
      issue_q <= advance; // Decode sees the word for exactly one cycle
      if (accept)
        pending_q <= 1'b0;                // Wrong-path word is gone now
      else if (redirect && state_q == REQ)
        pending_q <= 1'b1;                // Let the handshake close, then drop it
      case (state_q)
        IDLE:    state_q <= halt ? HALTED : REQ;
        REQ:     if (fetch_ack) state_q <= DROP; // Phase 3, req falls
        DROP: begin
          // Phase 4 seen, the port is free again
          if (!fetch_ack)
            state_q <= halt ? HALTED : IDLE;
        end
        HALTED:  state_q <= HALTED; // Only reset leaves here
        default: state_q <= IDLE;
      endcase
    end
  end

  // Word register, loaded only when it will be issued
  always_ff @(posedge clk) begin
    if (advance)
      instr_q <= fetch_instr;
  end

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

`include "cpu_defs.svh"

  //////////////////////////////////////////////////////////////////////
  // Instruction word
  //////////////////////////////////////////////////////////////////////

  // Opcodes in the top nibble, any value not listed executes as a no-op
  typedef enum logic [3:0] {
    ADD  = 4'd0,
    SUB  = 4'd1,
    AND  = 4'd2,
    XOR  = 4'd3,
    ADDI = 4'd4,
    LLI  = 4'd5,
    B    = 4'd6,
    HLT  = 4'd15
  } opcode_e;

  typedef struct packed {
    opcode_e                   opcode; // Operation
    logic [`CPU_REG_IDX_W-1:0] rd;     // Destination register
    logic [`CPU_REG_IDX_W-1:0] rs;     // First source register
    logic [`CPU_REG_IDX_W-1:0] rt;     // Second source register
  } r_fmt_t;

  typedef struct packed {
    opcode_e                   opcode; // Operation
    logic [`CPU_REG_IDX_W-1:0] rd;     // Destination, or branch condition for B
    logic [`CPU_IMM_W-1:0]     imm;    // Signed immediate
  } i_fmt_t;

  // The same 16 bits read either as register or immediate form
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  //////////////////////////////////////////////////////////////////////
  // Stage controls
  //////////////////////////////////////////////////////////////////////

  // ALU function; PASS hands operand b straight through for LLI
  typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_PASS} alu_op_e;

  typedef struct packed {
    logic [`CPU_DATA_W-1:0] op_a;      // Operand a from the register file
    logic [`CPU_DATA_W-1:0] op_b;      // Register or sign-extended immediate
    alu_op_e                alu_op;    // ALU function
    logic                   z_en;      // Update Z from this result
    logic                   nv_en;     // Update N and V from this result
    logic                   is_branch; // Conditional branch
    logic [1:0]             cond;      // 0 always, 1 Z set, 2 Z clear, 3 N set
    logic [`CPU_PC_W-1:0]   offset;    // Branch offset added to next PC
  } ex_ctrl_t;

  typedef struct packed {
    logic [`CPU_REG_IDX_W-1:0] rd;        // Register to write
    logic                      reg_write; // Result goes to rd
    logic                      hlt;       // Stop the core after this one
  } wb_ctrl_t;

  typedef struct packed {
    logic z; // Result was zero
    logic n; // Result was negative
    logic v; // Signed overflow
  } flags_t;

  // One register write, also seen on the observation port
  typedef struct packed {
    logic                      valid;
    logic [`CPU_REG_IDX_W-1:0] rd;
    logic [`CPU_DATA_W-1:0]    data;
  } wb_port_t;

endpackage

// ==== source/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Core widths and sizes
//////////////////////////////////////////////////////////////////////

// Data path and register width
`define CPU_DATA_W 16

// Fetch PC width, one instruction word per address
`define CPU_PC_W 16

`define CPU_NREGS 16    // Entries in the register file
`define CPU_REG_IDX_W 4 // Bits needed to name one register

// Signed immediate field of the I-format
`define CPU_IMM_W 8

`endif
